// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_iic_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
LINTFLAGS ?= --lint-only
BINFLAGS  ?= --binary -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BINFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
verilog/iic_timing_pkg.sv
verilog/iic_cmd_pkg.sv
verilog/scl_timing.sv
verilog/cfg_regs.sv
verilog/byte_shifter.sv
verilog/iic_sequencer.sv
verilog/iic_top.sv
verification/eeprom_model.sv
verification/tb_iic_top.sv

// ==== verification/eeprom_model.sv ====
`timescale 1ns/100ps

module eeprom_model #(
  parameter logic [6:0] dev_id  = 7'h50,
  parameter int         hold_ns = 200      // data change after scl falls
) (
  input  logic scl,
  inout  wire  sda,
  output logic bad_dev
);

  typedef enum logic [2:0] {
    M_IDLE,
    M_DEV,
    M_ADDR,
    M_WRITE,
    M_READ
  } mode_e;

  logic [7:0] mem [256];
  logic [7:0] ptr;                  // eeprom address pointer
  logic [7:0] shreg;
  logic [3:0] bit_cnt;              // scl rises seen in this frame, 9 with the ack
  logic       sda_low;
  logic       nack;                 // master's answer to a read byte
  mode_e      mode;

  assign sda = sda_low ? 1'b0 : 1'bz;

  initial begin
    mode    = M_IDLE;
    bit_cnt = 4'd0;
    sda_low = 1'b0;
    nack    = 1'b0;
    bad_dev = 1'b0;
    ptr     = 8'h00;
    shreg   = 8'h00;
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 37) ^ 8'h5c;  // differs at every address
  end

  // a complete byte from the master
  task automatic take_byte;
    case (mode)
      M_DEV: begin
        if (shreg[7:1] != dev_id) begin
          $display("eeprom model: device address %h is not %h", shreg[7:1], dev_id);
          bad_dev = 1'b1;
        end
        mode = shreg[0] ? M_READ : M_ADDR;
        nack = 1'b0;
      end
      M_ADDR: begin
        ptr  = shreg;
        mode = M_WRITE;
      end
      default: begin
        mem[ptr] = shreg;
        ptr      = ptr + 8'd1;
      end
    endcase
  endtask

  // --------------------------------------------------
  // start, repeated start and stop
  // --------------------------------------------------
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      mode    = M_DEV;
      bit_cnt = 4'd0;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1) begin
      mode    = M_IDLE;
      bit_cnt = 4'd0;
    end
  end

  // --------------------------------------------------
  // bit level
  // --------------------------------------------------
  always @(posedge scl) begin
    if (mode != M_IDLE) begin
      if (bit_cnt == 4'd8)
        nack = sda;
      else if (bit_cnt < 4'd8 && mode != M_READ)
        shreg = {shreg[6:0], sda};
      bit_cnt = bit_cnt + 4'd1;
    end
  end

  always @(negedge scl) begin
    #(hold_ns);
    if (mode != M_IDLE) begin
      if (bit_cnt == 4'd8) begin
        if (mode == M_READ) begin
          sda_low = 1'b0;           // master answers
        end else begin
          take_byte();
          sda_low = 1'b1;           // acknowledge every byte
        end
      end else if (bit_cnt == 4'd9) begin
        bit_cnt = 4'd0;
        sda_low = 1'b0;
        if (mode == M_READ) begin
          if (nack) begin
            mode = M_IDLE;          // wait for the stop
          end else begin
            shreg   = mem[ptr];
            ptr     = ptr + 8'd1;
            sda_low = !shreg[7];
          end
        end
      end else if (mode == M_READ && bit_cnt != 4'd0) begin
        sda_low = !shreg[3'd7 - bit_cnt[2:0]];
      end
    end
  end

endmodule

// ==== verification/tb_iic_top.sv ====
`timescale 1ns/100ps

module tb_iic_top;

  localparam int         CLK_DIV = 100;
  localparam logic [6:0] DEV_ID  = 7'h50;

  // key masks where 1 means pressed
  localparam logic [2:0] K_WR = 3'b001;
  localparam logic [2:0] K_RD = 3'b010;
  localparam logic [2:0] K_PG = 3'b100;

  typedef struct packed {
    logic [2:0]  keys;
    logic [6:0]  dev;
    logic [7:0]  byte_addr;
    logic [2:0]  page_len;          // as written before the clamp
    logic [31:0] data;              // byte 0 in the low bits
    logic [7:0]  exp_rd;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_wr;
  iic_cmd_pkg::reg_addr_e addr;
  logic [7:0]             idat;
  logic                   write_key_n;
  logic                   read_key_n;
  logic                   page_key_n;
  logic                   scl;
  wire                    sda;
  logic [7:0]             outdata;
  logic [2:0]             ackflag;
  logic                   bad_dev;

  row_t        ops[$];              // operation table
  logic [7:0]  pred_mem [256];
  logic [31:0] lfsr = 32'h33fa_c342;
  logic [2:0]  exp_flag;
  int          cycles = 0;
  int          limit  = 0;

  pullup (sda);

  iic_top #(.clk_div(CLK_DIV)) dut (
    .clk, .rst_n, .reg_wr, .addr, .idat,
    .write_key_n, .read_key_n, .page_key_n,
    .scl, .sda, .outdata, .ackflag
  );

  eeprom_model #(.dev_id(DEV_ID)) eeprom (
    .scl, .sda, .bad_dev
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // failure reporting and checks
  // --------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit)
      fail_run("run timed out before the operation table finished");
  end

  always @(posedge bad_dev)
    fail_run("a transfer addressed a device other than the eeprom");

  // --------------------------------------------------
  // table construction
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic add_row(input logic [2:0] keys, input logic [7:0] a, input logic [2:0] len);
    row_t       r;
    logic [7:0] b;
    r           = '0;
    r.keys      = keys;
    r.dev       = DEV_ID;
    r.byte_addr = a;
    r.page_len  = len;
    for (int i = 0; i < 4; i++) begin
      next_byte(b);
      r.data[8*i +: 8] = b;
    end
    ops.push_back(r);
  endtask

  task automatic add_reads(input logic [7:0] a, input int n);
    for (int i = 0; i < n; i++)
      add_row(K_RD, a + 8'(i), 3'd1);
  endtask

  // bytes moved by a page write
  function automatic int page_count(input logic [2:0] raw);
    if (raw == 3'd0)
      return 1;
    return (int'(raw) > iic_cmd_pkg::PAGE_MAX) ? iic_cmd_pkg::PAGE_MAX : int'(raw);
  endfunction

  task automatic predict_reads;
    row_t r;
    int   n;
    for (int i = 0; i < 256; i++)
      pred_mem[i] = eeprom.mem[i];
    foreach (ops[k]) begin
      r = ops[k];
      if (r.keys[0]) begin
        pred_mem[r.byte_addr] = r.data[7:0];    // write wins over read
      end else if (r.keys[1]) begin
        r.exp_rd = pred_mem[r.byte_addr];
      end else begin
        n = page_count(r.page_len);
        for (int j = 0; j < n; j++)
          pred_mem[8'(r.byte_addr + 8'(j))] = r.data[8*j +: 8];
      end
      ops[k] = r;
    end
  endtask

  // --------------------------------------------------
  // bus stimulus
  // --------------------------------------------------
  task automatic write_reg(input iic_cmd_pkg::reg_addr_e a, input logic [7:0] d);
    addr   = a;
    idat   = d;
    reg_wr = 1'b1;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  // sda rising while scl is high
  task automatic wait_stop;
    do
      @(posedge sda);
    while (scl !== 1'b1);
  endtask

  task automatic apply_row(input row_t r);
    write_reg(iic_cmd_pkg::reg_dev, {1'b0, r.dev});
    write_reg(iic_cmd_pkg::reg_byte_addr, r.byte_addr);
    write_reg(iic_cmd_pkg::reg_page_len, {5'd0, r.page_len});
    // the data source that the operation does not use holds the complement
    write_reg(iic_cmd_pkg::reg_wdata, r.keys[2] ? ~r.data[7:0] : r.data[7:0]);
    for (int i = 0; i < iic_cmd_pkg::PAGE_MAX; i++)
      write_reg(iic_cmd_pkg::reg_addr_e'(3'd4 + 3'(i)),
                r.keys[2] ? r.data[8*i +: 8] : ~r.data[8*i +: 8]);
    write_key_n = !r.keys[0];
    read_key_n  = !r.keys[1];
    page_key_n  = !r.keys[2];
    wait_stop();
    @(negedge clk);
    write_key_n = 1'b1;             // released before idle samples again
    read_key_n  = 1'b1;
    page_key_n  = 1'b1;
  endtask

  initial begin
    rst_n       = 1'b0;
    reg_wr      = 1'b0;
    addr        = iic_cmd_pkg::reg_dev;
    idat        = 8'h00;
    write_key_n = 1'b1;
    read_key_n  = 1'b1;
    page_key_n  = 1'b1;
    exp_flag    = 3'd0;

    add_row(K_WR, 8'h10, 3'd1);
    add_reads(8'h10, 1);
    add_row(K_PG, 8'h20, 3'd1);
    add_reads(8'h20, 2);
    add_row(K_PG, 8'h30, 3'd4);
    add_reads(8'h30, 5);
    add_row(K_PG, 8'h40, 3'd2);
    add_reads(8'h40, 3);
    add_row(K_PG, 8'h50, 3'd3);
    add_reads(8'h50, 4);
    add_row(K_PG, 8'h60, 3'd0);     // clamps to one byte
    add_reads(8'h60, 2);
    add_row(K_PG, 8'h70, 3'd7);     // clamps to four bytes
    add_reads(8'h70, 5);
    add_row(K_WR | K_RD, 8'h80, 3'd1);
    add_reads(8'h80, 1);
    limit = ops.size() * 60 * CLK_DIV + 16;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    if (sda !== 1'b1)
      fail_run("sda is not released after reset");
    if (scl !== 1'b0)
      fail_run("scl is not low after reset");
    check_byte("outdata", outdata, 8'h00);
    check_flag("ackflag", ackflag, 3'd0);

    predict_reads();
    foreach (ops[i]) begin
      apply_row(ops[i]);
      if (!ops[i].keys[0] && ops[i].keys[1]) begin
        exp_flag = exp_flag + 3'd1;             // wraps after eight reads
        check_byte("outdata", outdata, ops[i].exp_rd);
      end
      check_flag("ackflag", ackflag, exp_flag);
    end

    $display("sim passed");
    $finish;
  end

endmodule

// ==== verilog/byte_shifter.sv ====
`timescale 1ns/100ps

module byte_shifter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [7:0] load_byte,
  input  logic       shift_out,
  input  logic       shift_in,
  input  logic       sda_in,
  output logic       tx_bit,
  output logic [7:0] rx_byte,
  output logic       done
);

  logic [7:0] sreg;                 // shared by transmit and receive
  logic [3:0] bit_cnt;              // 0 to 8

  // pulses with the strobe that moves the eighth bit
  assign done    = (shift_out || shift_in) && (bit_cnt == 4'd7);
  assign rx_byte = sreg;

  // --------------------------------------------------
  // byte register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (load)
      sreg <= load_byte;
    else if (shift_out)
      sreg <= {sreg[6:0], 1'b0};    // msb first
    else if (shift_in)
      sreg <= {sreg[6:0], sda_in};
  end

  // --------------------------------------------------
  // bit count and line bit
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= 4'd0;
      tx_bit  <= 1'b1;              // idle level of the bus
    end else if (load) begin
      bit_cnt <= 4'd0;
    end else if (shift_out || shift_in) begin
      if (bit_cnt != 4'd8)
        bit_cnt <= bit_cnt + 4'd1;
      if (shift_out)
        tx_bit <= sreg[7];          // held for one scl period
    end
  end

endmodule

// ==== verilog/cfg_regs.sv ====
`timescale 1ns/100ps

module cfg_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reg_wr,
  input  iic_cmd_pkg::reg_addr_e addr,
  input  logic [7:0]            idat,
  input  logic [1:0]            page_idx,
  output iic_cmd_pkg::cmd_t     cmd,
  output logic [7:0]            page_byte
);

  localparam logic [2:0] LEN_MAX = 3'(iic_cmd_pkg::PAGE_MAX);

  logic [7:0] page_data [iic_cmd_pkg::PAGE_MAX];

  // --------------------------------------------------
  // host writes
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd          <= '0;
      cmd.page_len <= 3'd1;
      for (int i = 0; i < iic_cmd_pkg::PAGE_MAX; i++)
        page_data[i] <= 8'h00;
    end else if (reg_wr) begin
      case (addr)
        iic_cmd_pkg::reg_dev:       cmd.dev       <= idat[6:0];
        iic_cmd_pkg::reg_byte_addr: cmd.byte_addr <= idat;
        iic_cmd_pkg::reg_page_len: begin
          if (idat[2:0] == 3'd0)
            cmd.page_len <= 3'd1;             // at least one byte
          else if (idat[2:0] > LEN_MAX)
            cmd.page_len <= LEN_MAX;
          else
            cmd.page_len <= idat[2:0];
        end
        iic_cmd_pkg::reg_wdata:     cmd.wdata     <= idat;
        default:                    page_data[addr[1:0]] <= idat;  // page bytes 0..3
      endcase
    end
  end

  // page byte for the sequencer, one clock behind page_idx
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      page_byte <= 8'h00;
    else
      page_byte <= page_data[page_idx];
  end

endmodule

// ==== verilog/iic_cmd_pkg.sv ====
package iic_cmd_pkg;

  localparam int PAGE_MAX = 4;      // page data registers

  // --------------------------------------------------
  // host register map
  // --------------------------------------------------
  typedef enum logic [2:0] {
    reg_dev       = 3'd0,           // 7-bit device address
    reg_byte_addr = 3'd1,           // eeprom byte address
    reg_page_len  = 3'd2,           // bytes per page write
    reg_wdata     = 3'd3,           // single write byte
    reg_page0     = 3'd4,
    reg_page1     = 3'd5,
    reg_page2     = 3'd6,
    reg_page3     = 3'd7
  } reg_addr_e;

  typedef enum logic [1:0] {
    op_none       = 2'd0,
    op_byte_write = 2'd1,
    op_byte_read  = 2'd2,
    op_page_write = 2'd3
  } op_e;

  typedef struct packed {
    logic [6:0] dev;
    logic [7:0] byte_addr;
    logic [2:0] page_len;           // 1 to PAGE_MAX
    logic [7:0] wdata;
  } cmd_t;

endpackage

// ==== verilog/iic_sequencer.sv ====
`timescale 1ns/100ps

module iic_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  iic_timing_pkg::phase_t phase,
  input  iic_cmd_pkg::cmd_t      cmd,
  input  logic                   write_key_n,
  input  logic                   read_key_n,
  input  logic                   page_key_n,
  input  logic [7:0]             page_byte,
  input  logic                   tx_bit,
  input  logic                   done,
  output logic [1:0]             page_idx,
  output logic                   load,
  output logic [7:0]             load_byte,
  output logic                   shift_out,
  output logic                   shift_in,
  output logic                   sda_oe,
  output logic                   sda_drive,
  output logic                   rd_valid
);

  typedef enum logic [12:0] {
    IDLE     = 13'b0_0000_0000_0001,
    START    = 13'b0_0000_0000_0010,  // first start and repeated start
    DEV      = 13'b0_0000_0000_0100,
    ACK_DEV  = 13'b0_0000_0000_1000,
    ADDR     = 13'b0_0000_0001_0000,
    ACK_ADDR = 13'b0_0000_0010_0000,
    WDATA    = 13'b0_0000_0100_0000,
    ACK_DATA = 13'b0_0000_1000_0000,
    RDEV     = 13'b0_0001_0000_0000,
    ACK_RDEV = 13'b0_0010_0000_0000,
    RDATA    = 13'b0_0100_0000_0000,
    NACK     = 13'b0_1000_0000_0000,
    STOP     = 13'b1_0000_0000_0000
  } state_e;

  state_e             state;
  iic_cmd_pkg::op_e   op;           // latched for the whole transaction
  logic               armed;        // second step of a two-strobe bit
  logic               rep;          // next start is the repeated one
  logic               more;         // page bytes left after this one
  logic               tx_sel;       // line follows the shifter
  logic               sda_r;        // line level outside of data bytes
  logic               send_st;
  logic               last_page;

  assign send_st   = (state == DEV) || (state == ADDR) || (state == WDATA) || (state == RDEV);
  assign last_page = ({1'b0, page_idx} == cmd.page_len - 3'd1);

  // --------------------------------------------------
  // shifter control
  // --------------------------------------------------
  assign shift_out = send_st && phase.low && !armed;
  assign shift_in  = (state == RDATA) && phase.high;
  assign sda_drive = tx_sel ? tx_bit : sda_r;

  always_comb begin
    load      = 1'b0;
    load_byte = 8'hff;              // receive side only needs the count cleared
    case (state)
      START: begin
        load      = phase.high && armed;
        load_byte = {cmd.dev, rep};           // r/w bit
      end
      ACK_DEV: begin
        load      = phase.neg;
        load_byte = cmd.byte_addr;
      end
      ACK_ADDR: begin
        load      = phase.neg && (op != iic_cmd_pkg::op_byte_read);
        load_byte = (op == iic_cmd_pkg::op_page_write) ? page_byte : cmd.wdata;
      end
      ACK_DATA: begin
        load      = phase.neg && more;
        load_byte = page_byte;
      end
      ACK_RDEV: load = phase.neg;
      default: ;
    endcase
  end

  // --------------------------------------------------
  // transaction FSM
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      op       <= iic_cmd_pkg::op_none;
      armed    <= 1'b0;
      rep      <= 1'b0;
      more     <= 1'b0;
      tx_sel   <= 1'b0;
      sda_r    <= 1'b1;
      sda_oe   <= 1'b0;
      page_idx <= 2'd0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        IDLE: begin
          sda_oe   <= 1'b0;
          sda_r    <= 1'b1;
          armed    <= 1'b0;
          rep      <= 1'b0;
          tx_sel   <= 1'b0;
          page_idx <= 2'd0;
          if (!write_key_n)
            op <= iic_cmd_pkg::op_byte_write;   // write wins
          else if (!read_key_n)
            op <= iic_cmd_pkg::op_byte_read;
          else if (!page_key_n)
            op <= iic_cmd_pkg::op_page_write;
          else
            op <= iic_cmd_pkg::op_none;
          if (!write_key_n || !read_key_n || !page_key_n)
            state <= START;
        end
        START: begin
          if (phase.low) begin
            sda_oe <= 1'b1;
            sda_r  <= 1'b1;          // line high before scl rises
            armed  <= 1'b1;
          end else if (phase.high && armed) begin
            sda_r <= 1'b0;           // sda falls with scl high
            armed <= 1'b0;
            state <= rep ? RDEV : DEV;
          end
        end
        DEV, ADDR, WDATA, RDEV: begin
          if (phase.low && armed) begin
            sda_oe <= 1'b0;          // slave acknowledge bit
            tx_sel <= 1'b0;
            armed  <= 1'b0;
            case (state)
              DEV:   state <= ACK_DEV;
              ADDR:  state <= ACK_ADDR;
              RDEV:  state <= ACK_RDEV;
              default: begin
                state <= ACK_DATA;
                more  <= (op == iic_cmd_pkg::op_page_write) && !last_page;
                if ((op == iic_cmd_pkg::op_page_write) && !last_page)
                  page_idx <= page_idx + 2'd1;  // page_byte ready by the neg strobe
              end
            endcase
          end else if (phase.low) begin
            sda_oe <= 1'b1;
            tx_sel <= 1'b1;
            if (done)
              armed <= 1'b1;         // eighth bit on the line
          end
        end
        ACK_DEV:  if (phase.neg) state <= ADDR;
        ACK_ADDR: begin
          if (phase.neg) begin
            if (op == iic_cmd_pkg::op_byte_read) begin
              rep   <= 1'b1;
              state <= START;
            end else begin
              state <= WDATA;
            end
          end
        end
        ACK_DATA: if (phase.neg) state <= more ? WDATA : STOP;
        ACK_RDEV: if (phase.neg) state <= RDATA;
        RDATA: begin
          if (shift_in && done) begin
            rd_valid <= 1'b1;
            state    <= NACK;
          end
        end
        NACK: begin
          if (phase.low) begin
            sda_oe <= 1'b1;
            sda_r  <= 1'b1;          // not-acknowledge ends the read
            armed  <= 1'b1;
          end else if (phase.neg && armed) begin
            armed <= 1'b0;
            state <= STOP;
          end
        end
        STOP: begin
          if (phase.low) begin
            sda_oe <= 1'b1;
            sda_r  <= 1'b0;
            armed  <= 1'b1;
          end else if (phase.high && armed) begin
            sda_r  <= 1'b1;
            sda_oe <= 1'b0;          // pull-up raises sda, stop
            armed  <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/iic_timing_pkg.sv ====
package iic_timing_pkg;

  // --------------------------------------------------
  // SCL divider
  // --------------------------------------------------
  localparam int SCL_DIV = 100;     // clocks per scl period

  // phase points, percent of the period
  localparam int HIGH_PCT = 25;     // middle of scl high
  localparam int NEG_PCT  = 52;     // just after scl falls
  localparam int LOW_PCT  = 76;     // middle of scl low
  localparam int POS_PCT  = 98;     // just before scl rises

  // --------------------------------------------------
  // phase strobes, one clock wide each period
  // --------------------------------------------------
  typedef struct packed {
    logic pos;                      // scl about to rise
    logic high;                     // sample point, start and stop
    logic neg;                      // scl just fell
    logic low;                      // data change point
  } phase_t;

endpackage

// ==== verilog/iic_top.sv ====
`timescale 1ns/100ps

module iic_top #(
  parameter int clk_div = iic_timing_pkg::SCL_DIV
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   reg_wr,
  input  iic_cmd_pkg::reg_addr_e addr,
  input  logic [7:0]             idat,
  input  logic                   write_key_n,
  input  logic                   read_key_n,
  input  logic                   page_key_n,
  output logic                   scl,
  inout  wire                    sda,
  output logic [7:0]             outdata,
  output logic [2:0]             ackflag
);

  iic_timing_pkg::phase_t phase;
  iic_cmd_pkg::cmd_t      cmd;
  logic [1:0] page_idx;
  logic [7:0] page_byte;
  logic       load;
  logic [7:0] load_byte;
  logic       shift_out;
  logic       shift_in;
  logic       tx_bit;
  logic [7:0] rx_byte;
  logic       done;
  logic       sda_oe;
  logic       sda_drive;
  logic       rd_valid;

  // open drain, a 1 comes from the pull-up
  assign sda = (sda_oe && !sda_drive) ? 1'b0 : 1'bz;

  scl_timing #(.clk_div(clk_div)) u_scl_timing (
    .clk, .rst_n, .scl, .phase
  );

  cfg_regs u_cfg_regs (
    .clk, .rst_n, .reg_wr, .addr, .idat, .page_idx, .cmd, .page_byte
  );

  byte_shifter u_byte_shifter (
    .clk, .rst_n, .load, .load_byte, .shift_out, .shift_in,
    .sda_in(sda), .tx_bit, .rx_byte, .done
  );

  iic_sequencer u_iic_sequencer (
    .clk, .rst_n, .phase, .cmd, .write_key_n, .read_key_n, .page_key_n,
    .page_byte, .tx_bit, .done, .page_idx, .load, .load_byte,
    .shift_out, .shift_in, .sda_oe, .sda_drive, .rd_valid
  );

  // --------------------------------------------------
  // read result
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outdata <= 8'h00;
      ackflag <= 3'd0;
    end else if (rd_valid) begin
      outdata <= rx_byte;
      ackflag <= ackflag + 3'd1;     // wraps after eight reads
    end
  end

endmodule

// ==== verilog/scl_timing.sv ====
`timescale 1ns/100ps

module scl_timing #(
  parameter int clk_div = iic_timing_pkg::SCL_DIV
) (
  input  logic                   clk,
  input  logic                   rst_n,
  output logic                   scl,
  output iic_timing_pkg::phase_t phase
);

  localparam int CW = $clog2(clk_div);

  localparam logic [CW-1:0] LAST   = CW'(clk_div - 1);
  localparam logic [CW-1:0] HALF   = CW'(clk_div / 2 - 1);
  localparam logic [CW-1:0] P_HIGH = CW'(clk_div * iic_timing_pkg::HIGH_PCT / 100);
  localparam logic [CW-1:0] P_NEG  = CW'(clk_div * iic_timing_pkg::NEG_PCT / 100);
  localparam logic [CW-1:0] P_LOW  = CW'(clk_div * iic_timing_pkg::LOW_PCT / 100);
  localparam logic [CW-1:0] P_POS  = CW'(clk_div * iic_timing_pkg::POS_PCT / 100);

  logic [CW-1:0] cnt;               // position in the scl period

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      scl   <= 1'b0;                // low until the first period starts
      phase <= '0;
    end else begin
      cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
      if (cnt == LAST)
        scl <= 1'b1;                // high for the first half
      else if (cnt == HALF)
        scl <= 1'b0;
      // decoded a clock early so the strobes leave a flop
      phase <= '{pos:  (cnt == P_POS),
                 high: (cnt == P_HIGH),
                 neg:  (cnt == P_NEG),
                 low:  (cnt == P_LOW)};
    end
  end

endmodule
